//--- project.f
src/lsu_pkg.sv
src/lsu.sv
src/sram.sv
src/clint.sv
src/lsu_top.sv
sim/tb_lsu_top.sv

//--- sim/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

    import lsu_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int REGION  = 64;    // sram words the test touches

    typedef struct packed {
        logic  check;
        word_t data;
    } beat_exp_t;

    logic        clock;
    logic        reset;
    logic        lsu_rvalid;
    logic        lsu_burst;
    logic        lsu_rsign;
    addr_t       lsu_raddr;
    len_t        lsu_rlen;
    mask_t       lsu_rmask;
    word_t       lsu_rdata;
    logic        lsu_rready;
    logic        lsu_wvalid;
    addr_t       lsu_waddr;
    word_t       lsu_wdata;
    mask_t       lsu_wmask;
    logic        lsu_wready;

    word_t       shadow [REGION];
    beat_exp_t   exp_q [$];
    beat_exp_t   head;
    logic [31:0] lfsr;
    int          cycle;
    int          errors;
    int          checks;

    lsu_top UUT (
        .clock      (clock),
        .reset      (reset),
        .lsu_rvalid (lsu_rvalid),
        .lsu_burst  (lsu_burst),
        .lsu_rsign  (lsu_rsign),
        .lsu_raddr  (lsu_raddr),
        .lsu_rlen   (lsu_rlen),
        .lsu_rmask  (lsu_rmask),
        .lsu_rdata  (lsu_rdata),
        .lsu_rready (lsu_rready),
        .lsu_wvalid (lsu_wvalid),
        .lsu_waddr  (lsu_waddr),
        .lsu_wdata  (lsu_wdata),
        .lsu_wmask  (lsu_wmask),
        .lsu_wready (lsu_wready)
    );

    always #50 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    // ------------------------------------------------------------------------
    // stimulus source and reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic addr_t word_addr(input int idx);
        return SRAM_BASE + addr_t'(idx << 2);
    endfunction

    // bytes of data land on the lanes starting at the address offset
    function automatic word_t merge_write(input word_t old, input word_t data,
                                          input logic [1:0] off, input mask_t mask);
        word_t res;
        int    nbytes;
        res    = old;
        nbytes = (mask == 2'd3) ? 4 : int'(mask);
        for (int i = 0; i < nbytes; i++)
            res[8*(off+i) +: 8] = data[8*i +: 8];
        return res;
    endfunction

    // addressed bytes moved down and extended from the top byte taken
    function automatic word_t expect_read(input word_t w, input logic [1:0] off,
                                          input mask_t mask, input logic sign);
        word_t res;
        int    nbytes;
        res    = '0;
        nbytes = (mask == 2'd3) ? 4 : int'(mask);
        for (int i = 0; i < nbytes; i++) begin
            if (int'(off) + i < 4)
                res[8*i +: 8] = w[8*(int'(off) + i) +: 8];
        end
        if (sign && nbytes > 0 && nbytes < 4 && res[8*nbytes-1])
            res = res | ('1 << (8 * nbytes));
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // request tasks
    // ------------------------------------------------------------------------

    task automatic finish_run;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic push_expect(input addr_t addr, input mask_t mask, input logic sign,
                               input logic burst, input len_t len, output int beats);
        int        idx;
        beat_exp_t e;
        idx   = int'((addr - SRAM_BASE) >> 2);
        beats = burst ? int'(len) + 1 : 1;
        for (int n = 0; n < beats; n++) begin
            e.check = 1'b1;
            e.data  = expect_read(shadow[idx + n], addr[1:0], mask, sign);
            exp_q.push_back(e);
        end
    endtask

    task automatic push_timer(input logic check, input word_t data);
        beat_exp_t e;
        e.check = check;
        e.data  = data;
        exp_q.push_back(e);
    endtask

    // request is taken at the next edge, response seen two edges later
    task automatic await_response(input logic wr);
        int    waited;
        string name;
        name = wr ? "lsu_wready" : "lsu_rready";
        @(posedge clock);
        @(negedge clock);
        waited = 1;
        while (!(wr ? lsu_wready : lsu_rready) && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!(wr ? lsu_wready : lsu_rready)) begin
            timed_out(name);
        end else begin
            checks++;
            if (waited != 2) begin
                errors++;
                $display("FAILED at %0t: %s latency got %0d expected 2",
                         $time, name, waited);
            end
        end
    endtask

    // drop valid after the final pulse and check that no extra pulse follows
    task automatic finish_request(input logic wr);
        @(posedge clock);
        #5;
        if (wr)
            lsu_wvalid = 1'b0;
        else
            lsu_rvalid = 1'b0;
        @(negedge clock);
        checks++;
        if ((wr ? lsu_wready : lsu_rready) !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: %s got 1 expected 0", $time,
                     wr ? "lsu_wready" : "lsu_rready");
        end
        @(posedge clock);
        #5;
    endtask

    task automatic write_req(input addr_t addr, input word_t data, input mask_t mask);
        int idx;
        lsu_wvalid = 1'b1;
        lsu_waddr  = addr;
        lsu_wdata  = data;
        lsu_wmask  = mask;
        await_response(1'b1);
        idx         = int'((addr - SRAM_BASE) >> 2);
        shadow[idx] = merge_write(shadow[idx], data, addr[1:0], mask);
        finish_request(1'b1);
    endtask

    task automatic read_req(input addr_t addr, input mask_t mask, input logic sign,
                            input logic burst, input len_t len, input int beats,
                            output word_t first, output int taken);
        lsu_rvalid = 1'b1;
        lsu_raddr  = addr;
        lsu_rmask  = mask;
        lsu_rsign  = sign;
        lsu_burst  = burst;
        lsu_rlen   = len;
        taken      = cycle;
        await_response(1'b0);
        first = lsu_rdata;
        // burst beats follow back to back
        for (int n = 1; n < beats; n++) begin
            @(negedge clock);
            checks++;
            if (!lsu_rready) begin
                errors++;
                $display("burst beat %0d of %0d missing at %0t", n + 1, beats, $time);
            end
        end
        finish_request(1'b0);
    endtask

    // ------------------------------------------------------------------------
    // read data checker with one expected entry per lsu_rready beat
    // ------------------------------------------------------------------------

    always @(negedge clock) begin
        if (!reset && lsu_rready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("lsu_rready pulsed at %0t with no read beat expected", $time);
            end else begin
                head = exp_q.pop_front();
                if (head.check) begin
                    checks++;
                    if (lsu_rdata !== head.data) begin
                        errors++;
                        $display("FAILED at %0t: lsu_rdata got %h expected %h",
                                 $time, lsu_rdata, head.data);
                    end
                end
            end
        end
    end

    initial begin
        int    beats;
        int    idx;
        int    ridx;
        int    gap;
        int    t1;
        int    t2;
        word_t v1;
        word_t v2;
        word_t data;
        mask_t mask;
        len_t  len;
        logic [1:0] off;

        clock      = 1'b0;
        reset      = 1'b1;
        lsu_rvalid = 1'b0;
        lsu_burst  = 1'b0;
        lsu_rsign  = 1'b0;
        lsu_raddr  = '0;
        lsu_rlen   = '0;
        lsu_rmask  = '0;
        lsu_wvalid = 1'b0;
        lsu_waddr  = '0;
        lsu_wdata  = '0;
        lsu_wmask  = '0;
        lfsr       = 32'h71e2a22c;

        repeat (16) @(posedge clock);
        #5;
        reset = 1'b0;

        // no pulses without a request
        repeat (8) begin
            @(negedge clock);
            checks++;
            if (lsu_rready !== 1'b0 || lsu_wready !== 1'b0) begin
                errors++;
                $display("FAILED at %0t: lsu_rready/lsu_wready got %b/%b expected 0/0",
                         $time, lsu_rready, lsu_wready);
            end
        end
        @(posedge clock);
        #5;

        // mtime high word still zero this soon after reset
        push_timer(1'b1, '0);
        read_req(CLINT_BASE + 4, 2'd3, 1'b0, 1'b0, '0, 1, v1, t1);

        for (idx = 0; idx < REGION; idx++)
            write_req(word_addr(idx), rand_bits(32), 2'd3);

        // sized writes at aligned offsets then a whole-word read back
        repeat (24) begin
            mask = mask_t'(1 + rand_bits(2) % 3);
            idx  = int'(rand_bits(6));
            case (mask)
                2'd1:    off = 2'(rand_bits(2));
                2'd2:    off = 2'(rand_bits(1) << 1);
                default: off = 2'd0;
            endcase
            write_req(word_addr(idx) + off, rand_bits(32), mask);
            push_expect(word_addr(idx), 2'd3, 1'b0, 1'b0, '0, beats);
            read_req(word_addr(idx), 2'd3, 1'b0, 1'b0, '0, beats, v1, t1);
        end

        // every offset, mask and sign flag
        repeat (3) begin
            idx = int'(rand_bits(6));
            for (int n = 0; n < 32; n++) begin
                push_expect(word_addr(idx) + n[1:0], n[3:2], n[4], 1'b0, '0, beats);
                read_req(word_addr(idx) + n[1:0], n[3:2], n[4], 1'b0, '0, beats, v1, t1);
            end
        end

        repeat (8) begin
            idx = int'(rand_bits(5));
            len = len_t'(rand_bits(3));
            push_expect(word_addr(idx), 2'd3, 1'b0, 1'b1, len, beats);
            read_req(word_addr(idx), 2'd3, 1'b0, 1'b1, len, beats, v1, t1);
        end
        // fixed-address request gives a single beat
        repeat (2) begin
            idx = int'(rand_bits(5));
            len = len_t'(1 + rand_bits(3));
            push_expect(word_addr(idx), 2'd3, 1'b0, 1'b0, len, beats);
            read_req(word_addr(idx), 2'd3, 1'b0, 1'b0, len, beats, v1, t1);
        end

        // mtime advances by one per cycle between two reads
        repeat (3) begin
            push_timer(1'b0, '0);
            read_req(CLINT_BASE, 2'd3, 1'b0, 1'b1, 8'd5, 1, v1, t1);
            gap = int'(rand_bits(4));
            repeat (gap) begin
                @(posedge clock);
                #5;
            end
            push_timer(1'b0, '0);
            read_req(CLINT_BASE, 2'd3, 1'b0, 1'b0, '0, 1, v2, t2);
            checks++;
            if (v2 - v1 !== word_t'(t2 - t1)) begin
                errors++;
                $display("FAILED at %0t: mtime delta got %0d expected %0d",
                         $time, v2 - v1, t2 - t1);
            end
        end

        // write and read to different words in the same cycle
        repeat (4) begin
            idx  = int'(rand_bits(6));
            ridx = (idx + 1 + int'(rand_bits(5))) % REGION;
            data = rand_bits(32);
            push_expect(word_addr(ridx), 2'd3, 1'b0, 1'b0, '0, beats);
            fork
                write_req(word_addr(idx), data, 2'd3);
                read_req(word_addr(ridx), 2'd3, 1'b0, 1'b0, '0, beats, v1, t1);
            join
            push_expect(word_addr(idx), 2'd3, 1'b0, 1'b0, '0, beats);
            read_req(word_addr(idx), 2'd3, 1'b0, 1'b0, '0, beats, v1, t1);
        end

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected read beats never arrived", exp_q.size());
        end
        finish_run();
    end

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic           clock,
    input  logic           reset,

    input  logic           lsu_rvalid,
    input  logic           lsu_burst,
    input  logic           lsu_rsign,
    input  lsu_pkg::addr_t lsu_raddr,
    input  lsu_pkg::len_t  lsu_rlen,
    input  lsu_pkg::mask_t lsu_rmask,
    output lsu_pkg::word_t lsu_rdata,
    output logic           lsu_rready,

    input  logic           lsu_wvalid,
    input  lsu_pkg::addr_t lsu_waddr,
    input  lsu_pkg::word_t lsu_wdata,
    input  lsu_pkg::mask_t lsu_wmask,
    output logic           lsu_wready
);

    import lsu_pkg::*;

    // sram read
    rd_req_t ar;
    logic    ar_valid;
    logic    ar_ready;
    word_t   r_data;
    logic    r_valid;

    // sram write
    wr_req_t aw;
    logic    aw_valid;
    logic    aw_ready;
    logic    b_valid;

    // timer read
    logic    ar_valid_clint;
    addr_t   clint_addr;
    word_t   clint_data;
    logic    clint_valid;

    lsu u_lsu (
        .clock          (clock),
        .reset          (reset),
        .lsu_rvalid     (lsu_rvalid),
        .lsu_raddr      (lsu_raddr),
        .lsu_rlen       (lsu_rlen),
        .lsu_burst      (lsu_burst),
        .lsu_rsign      (lsu_rsign),
        .lsu_rmask      (lsu_rmask),
        .lsu_rdata      (lsu_rdata),
        .lsu_rready     (lsu_rready),
        .lsu_wvalid     (lsu_wvalid),
        .lsu_waddr      (lsu_waddr),
        .lsu_wdata      (lsu_wdata),
        .lsu_wmask      (lsu_wmask),
        .lsu_wready     (lsu_wready),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r_data         (r_data),
        .r_valid        (r_valid),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .b_valid        (b_valid),
        .ar_valid_clint (ar_valid_clint),
        .clint_addr     (clint_addr),
        .clint_data     (clint_data),
        .clint_valid    (clint_valid)
    );

    sram u_sram (
        .clock    (clock),
        .reset    (reset),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_data   (r_data),
        .r_valid  (r_valid),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .b_valid  (b_valid)
    );

    clint u_clint (
        .clock    (clock),
        .reset    (reset),
        .ar_valid (ar_valid_clint),
        .addr     (clint_addr),
        .r_data   (clint_data),
        .r_valid  (clint_valid)
    );

endmodule

//--- src/clint.sv
`timescale 1ns/1ps

module clint (
    input  logic           clock,
    input  logic           reset,
    input  logic           ar_valid,
    input  lsu_pkg::addr_t addr,
    output lsu_pkg::word_t r_data,
    output logic           r_valid
);

    logic [63:0] mtime;

    // ------------------------------------------------------------------------
    // free-running machine timer
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // ------------------------------------------------------------------------
    // read port, answers on the next cycle
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= ar_valid;
        end
    end

    // bit 2 picks the high word
    always_ff @(posedge clock) begin
        if (ar_valid)
            r_data <= addr[2] ? mtime[63:32] : mtime[31:0];
    end

endmodule

//--- src/sram.sv
`timescale 1ns/1ps

module sram (
    input  logic             clock,
    input  logic             reset,

    // read address and data
    input  lsu_pkg::rd_req_t ar,
    input  logic             ar_valid,
    output logic             ar_ready,
    output lsu_pkg::word_t   r_data,
    output logic             r_valid,

    // single-beat write
    input  lsu_pkg::wr_req_t aw,
    input  logic             aw_valid,
    output logic             aw_ready,
    output logic             b_valid
);

    import lsu_pkg::*;

    word_t       mem [SRAM_WORDS];

    sram_state_t state;
    addr_t       ar_off;
    addr_t       aw_off;
    sram_idx_t   ar_idx;
    sram_idx_t   aw_idx;
    sram_idx_t   beat_idx;
    len_t        beats_left;
    logic        incr;
    logic        ar_take;
    logic        aw_take;

    // offsets from the sram base, upper bits beyond the depth ignored
    assign ar_off = ar.addr - SRAM_BASE;
    assign aw_off = aw.addr - SRAM_BASE;
    assign ar_idx = ar_off[SRAM_IDX_W+1:2];
    assign aw_idx = aw_off[SRAM_IDX_W+1:2];

    // no new read address while a burst is running
    assign ar_ready = (state == sram_idle);
    assign aw_ready = !b_valid;

    assign ar_take = ar_valid && ar_ready;
    assign aw_take = aw_valid && aw_ready;

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (aw_take) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (aw.strb[i])
                    mem[aw_idx][8*i +: 8] <= aw.data[8*i +: 8];
            end
        end
    end

    // response one cycle after acceptance
    always_ff @(posedge clock) begin
        if (reset) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= aw_take;
        end
    end

    // ------------------------------------------------------------------------
    // read burst
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= sram_idle;
            r_valid    <= 1'b0;
            beats_left <= '0;
        end else begin
            case (state)
                sram_idle: begin
                    r_valid <= ar_take;
                    if (ar_take && (ar.len != '0)) begin
                        state      <= sram_burst;
                        beats_left <= ar.len;
                    end
                end
                sram_burst: begin
                    r_valid    <= 1'b1;
                    beats_left <= beats_left - 1'b1;
                    // last remaining beat goes out this cycle
                    if (beats_left == len_t'(1))
                        state <= sram_idle;
                end
                default: state <= sram_idle;
            endcase
        end
    end

    // first beat on acceptance, the rest from the latched index
    always_ff @(posedge clock) begin
        if (ar_take) begin
            r_data   <= mem[ar_idx];
            beat_idx <= ar.burst ? ar_idx + 1'b1 : ar_idx;
            incr     <= ar.burst;
        end else if (state == sram_burst) begin
            r_data <= mem[beat_idx];
            if (incr)
                beat_idx <= beat_idx + 1'b1;
        end
    end

endmodule

//--- src/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic             clock,
    input  logic             reset,

    // core read request
    input  logic             lsu_rvalid,
    input  lsu_pkg::addr_t   lsu_raddr,
    input  lsu_pkg::len_t    lsu_rlen,
    input  logic             lsu_burst,
    input  logic             lsu_rsign,
    input  lsu_pkg::mask_t   lsu_rmask,
    output lsu_pkg::word_t   lsu_rdata,
    output logic             lsu_rready,

    // core write request
    input  logic             lsu_wvalid,
    input  lsu_pkg::addr_t   lsu_waddr,
    input  lsu_pkg::word_t   lsu_wdata,
    input  lsu_pkg::mask_t   lsu_wmask,
    output logic             lsu_wready,

    // sram read
    output lsu_pkg::rd_req_t ar,
    output logic             ar_valid,
    input  logic             ar_ready,
    input  lsu_pkg::word_t   r_data,
    input  logic             r_valid,

    // sram write
    output lsu_pkg::wr_req_t aw,
    output logic             aw_valid,
    input  logic             aw_ready,
    input  logic             b_valid,

    // timer read
    output logic             ar_valid_clint,
    output lsu_pkg::addr_t   clint_addr,
    input  lsu_pkg::word_t   clint_data,
    input  logic             clint_valid
);

    import lsu_pkg::*;

    // access width code to axi size
    function automatic size_t mask_size(input mask_t mask);
        case (mask)
            2'd2:    return 3'd1;
            2'd3:    return 3'd2;
            default: return 3'd0;
        endcase
    endfunction

    rd_state_t rd_state;
    wr_state_t wr_state;

    logic      is_clint;
    logic      rd_take;
    logic      ar_accept;
    logic      beat;
    logic      rend;
    len_t      rd_len;
    len_t      rd_count;
    word_t     rout;
    word_t     rshift;

    word_t     wshift;
    strb_t     wstrb;

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------

    // timer window decoded once, everything else goes to sram
    assign is_clint = (lsu_raddr >= CLINT_BASE) && (lsu_raddr <= CLINT_END);

    // the timer answers a single beat only
    assign rd_len    = (lsu_burst && !is_clint) ? lsu_rlen : '0;
    assign rd_take   = lsu_rvalid && (rd_state == rd_idle);
    assign ar_accept = is_clint || ar_ready;
    assign beat      = (rd_state == rd_data) && (is_clint ? clint_valid : r_valid);
    assign rend      = (rd_count == rd_len);

    assign ar_valid       = (rd_state == rd_addr) && !is_clint;
    assign ar_valid_clint = (rd_state == rd_addr) && is_clint;
    assign clint_addr     = lsu_raddr;

    assign ar = '{
        addr:  lsu_raddr,
        size:  mask_size(lsu_rmask),
        len:   rd_len,
        burst: lsu_burst
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (rd_take)
                        rd_state <= rd_addr;
                end
                rd_addr: begin
                    if (ar_accept)
                        rd_state <= rd_data;
                end
                rd_data: begin
                    if (beat && rend)
                        rd_state <= rd_idle;
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // beat counter, wraps to zero on the last beat
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_count <= '0;
        end else if (rd_take) begin
            rd_count <= '0;
        end else if (beat) begin
            rd_count <= rend ? '0 : rd_count + 1'b1;
        end
    end

    // shift the addressed lane down to bit 0
    assign rout   = is_clint ? clint_data : r_data;
    assign rshift = rout >> {lsu_raddr[1:0], 3'b000};

    always_comb begin
        case (lsu_rmask)
            2'd1:    lsu_rdata = {{24{rshift[7] & lsu_rsign}}, rshift[7:0]};
            2'd2:    lsu_rdata = {{16{rshift[15] & lsu_rsign}}, rshift[15:0]};
            2'd3:    lsu_rdata = rshift;
            default: lsu_rdata = '0;
        endcase
    end

    assign lsu_rready = beat;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------

    // data moves up onto the lanes picked by the low address bits
    assign wshift = lsu_wdata << {lsu_waddr[1:0], 3'b000};

    always_comb begin
        case (lsu_wmask)
            2'd1:    wstrb = 4'b0001 << lsu_waddr[1:0];
            2'd2:    wstrb = lsu_waddr[1] ? 4'b1100 : 4'b0011;
            2'd3:    wstrb = 4'b1111;
            default: wstrb = 4'b0000;
        endcase
    end

    assign aw = '{
        addr: lsu_waddr,
        data: wshift,
        strb: wstrb,
        size: mask_size(lsu_wmask)
    };

    assign aw_valid   = (wr_state == wr_send);
    assign lsu_wready = (wr_state == wr_resp) && b_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (lsu_wvalid)
                        wr_state <= wr_send;
                end
                wr_send: begin
                    if (aw_ready)
                        wr_state <= wr_resp;
                end
                wr_resp: begin
                    if (b_valid)
                        wr_state <= wr_idle;
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

    // ------------------------------------------------------------------------
    // basic widths
    // ------------------------------------------------------------------------

    // byte address
    typedef logic [31:0] addr_t;
    // data word
    typedef logic [31:0] word_t;
    // one strobe bit per byte lane
    typedef logic [3:0]  strb_t;
    // axi transfer size, 0 byte, 1 half, 2 word
    typedef logic [2:0]  size_t;
    // burst length minus one
    typedef logic [7:0]  len_t;
    // access width code from the core, 0 none, 1 byte, 2 half, 3 word
    typedef logic [1:0]  mask_t;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------

    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_END  = 32'h0200_ffff;
    localparam addr_t SRAM_BASE  = 32'h8000_0000;

    localparam int SRAM_WORDS = 1024;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    // word index into the sram array
    typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

    // ------------------------------------------------------------------------
    // bus requests
    // ------------------------------------------------------------------------

    // read address channel
    typedef struct packed {
        addr_t addr;
        size_t size;
        len_t  len;
        logic  burst;   // incrementing when set
    } rd_req_t;

    // write address and data, single beat
    typedef struct packed {
        addr_t addr;
        word_t data;    // already on its byte lanes
        strb_t strb;
        size_t size;
    } wr_req_t;

    // ------------------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data
    } rd_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_send,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        sram_idle,
        sram_burst
    } sram_state_t;

endpackage
